// ==== logic/aluPkg.sv ====
// Shared definitions for the 16-bit arithmetic calculator.
// Widths, opcode encoding and the packed structs passed between the blocks.

`default_nettype none

package aluPkg;

	// ------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------

	// One operand.
	localparam int operandWidth = 16;
	// Full product width, also the result bus.
	localparam int resultWidth = 32;
	// Opcode field.
	localparam int opWidth = 4;
	// One select line per opcode value.
	localparam int opCount = 2 ** opWidth;
	// Row 0 is formed from a[0] directly, so one row less than the operand.
	localparam int mulRows = operandWidth - 1;

	typedef logic [operandWidth-1:0] operand_t;
	typedef logic [resultWidth-1:0] result_t;

	// ------------------------------------------------------------
	// Opcodes and bundles
	// ------------------------------------------------------------

	// Codes not listed here produce a zero result.
	typedef enum logic [opWidth-1:0] {
		opMul = 4'd2,
		opDiv = 4'd3,
		opMod = 4'd4,
		opAdd = 4'd10,
		opSub = 4'd11
	} aluOp_e;

	typedef struct packed {
		operand_t a;
		operand_t b;
		aluOp_e op;
	} aluRequest_t;

	// Divide-by-zero in the high bit, overflow in the low bit.
	typedef struct packed {
		logic divideByZero;
		logic overflow;
	} aluError_t;

	// Raw outputs of all arithmetic units, before selection.
	typedef struct packed {
		operand_t sum;
		logic addOverflow;
		result_t product;
		operand_t quotient;
		operand_t remainder;
		logic divideByZero;
	} arithResults_t;

endpackage

`default_nettype wire

// ==== logic/addSubUnit.sv ====
// Ripple-carry adder/subtractor for two 16-bit operands.
// Subtract is a plus inverted b plus one; overflow is the carry out for add
// and the carry-in/carry-out disagreement at the top bit for subtract.

`timescale 1ns/1ps
`default_nettype none

module addSubUnit (
	input wire aluPkg::operand_t a,
	input wire aluPkg::operand_t b,
	input wire aluPkg::aluOp_e op,
	output aluPkg::operand_t sum,
	output logic overflow
);

	// High for subtract, low for add and every other code.
	logic subMode;
	// Operand b after conditional inversion.
	aluPkg::operand_t bEff;
	// Carry into each bit, plus the final carry out.
	logic [aluPkg::operandWidth:0] carry;

	// ------------------------------------------------------------
	// Mode and operand conditioning
	// ------------------------------------------------------------

	assign subMode = (op == aluPkg::opSub);

	// Ones complement of b in subtract mode.
	assign bEff = b ^ {aluPkg::operandWidth{subMode}};

	// The extra one of the twos complement enters as carry-in.
	assign carry[0] = subMode;

	// ------------------------------------------------------------
	// Full-adder chain
	// ------------------------------------------------------------

	for (genvar i = 0; i < aluPkg::operandWidth; i++)
	begin : gBit
		// Propagate term of this cell.
		logic halfSum;

		assign halfSum = a[i] ^ bEff[i];
		assign sum[i] = halfSum ^ carry[i];
		// Generate, or propagate the incoming carry.
		assign carry[i+1] = (a[i] & bEff[i]) | (halfSum & carry[i]);
	end

	// ------------------------------------------------------------
	// Overflow rule
	// ------------------------------------------------------------

	// Add: unsigned carry out.
	// Subtract: carries into and out of the top bit differ.
	assign overflow = subMode
		? (carry[aluPkg::operandWidth-1] ^ carry[aluPkg::operandWidth])
		: carry[aluPkg::operandWidth];

endmodule

`default_nettype wire

// ==== logic/multiplierRow.sv ====
// One row of the shift-and-add array multiplier.
// Adds the gated multiplicand to the previous partial sum shifted right by one.

`timescale 1ns/1ps
`default_nettype none

module multiplierRow (
	input wire aluPkg::operand_t partial,
	input wire logic carryIn,
	input wire aluPkg::operand_t multiplicand,
	input wire logic multiplierBit,
	output logic productBit,
	output aluPkg::operand_t nextPartial,
	output logic carryOut
);

	// Previous partial sum moved down one place.
	aluPkg::operand_t shifted;
	// Multiplicand, or zero when this multiplier bit is clear.
	aluPkg::operand_t addend;

	// ------------------------------------------------------------
	// Row inputs
	// ------------------------------------------------------------

	// Low bit of the previous row has already left as a product bit.
	// Previous carry drops into the top position.
	assign shifted = {carryIn, partial[aluPkg::operandWidth-1:1]};

	// Partial product for this multiplier bit.
	assign addend = multiplicand & {aluPkg::operandWidth{multiplierBit}};

	// ------------------------------------------------------------
	// Row adder
	// ------------------------------------------------------------

	// 17-bit result keeps the carry for the next row.
	assign {carryOut, nextPartial} = shifted + addend;

	// Lowest bit of this row is final.
	assign productBit = nextPartial[0];

endmodule

`default_nettype wire

// ==== logic/arrayMultiplier.sv ====
// Unsigned 16 x 16 array multiplier.
// Row 0 is a[0] gating b, then one shift-and-add row per remaining bit of a.
// Each row retires one product bit; the last row supplies the top half.

`timescale 1ns/1ps
`default_nettype none

module arrayMultiplier (
	input wire aluPkg::operand_t a,
	input wire aluPkg::operand_t b,
	output aluPkg::result_t product
);

	// Partial sum leaving each row, index 0 is the initial row.
	aluPkg::operand_t partialChain [aluPkg::mulRows+1];
	// Carry leaving each row, index 0 feeds the first adder row.
	logic [aluPkg::mulRows:0] carryChain;
	// One retired product bit per adder row.
	logic [aluPkg::mulRows-1:0] rowBits;

	// ------------------------------------------------------------
	// First partial product
	// ------------------------------------------------------------

	// b gated by the low bit of a.
	assign partialChain[0] = b & {aluPkg::operandWidth{a[0]}};

	// Nothing to carry before the first addition.
	assign carryChain[0] = 1'b0;

	// ------------------------------------------------------------
	// Adder rows
	// ------------------------------------------------------------

	for (genvar r = 0; r < aluPkg::mulRows; r++)
	begin : gRow
		// Row r handles multiplier bit a[r+1].
		multiplierRow uRow (
			.partial(partialChain[r]),
			.carryIn(carryChain[r]),
			.multiplicand(b),
			.multiplierBit(a[r+1]),
			.productBit(rowBits[r]),
			.nextPartial(partialChain[r+1]),
			.carryOut(carryChain[r+1])
		);
	end

	// ------------------------------------------------------------
	// Product assembly
	// ------------------------------------------------------------

	// Bit 0 comes straight from the first partial product.
	// Bits 15 down to 1 are the retired row bits.
	// Last row's remaining partial fills bits 30 down to 16, its carry bit 31.
	assign product = {
		carryChain[aluPkg::mulRows],
		partialChain[aluPkg::mulRows][aluPkg::operandWidth-1:1],
		rowBits,
		partialChain[0][0]
	};

endmodule

`default_nettype wire

// ==== logic/divideUnit.sv ====
// Unsigned 16-bit divider.
// Produces quotient and remainder, both zero when the divisor is zero.

`timescale 1ns/1ps
`default_nettype none

module divideUnit (
	input wire aluPkg::operand_t dividend,
	input wire aluPkg::operand_t divisor,
	output aluPkg::operand_t quotient,
	output aluPkg::operand_t remainder,
	output logic divideByZero
);

	// Raw divider outputs, undefined for a zero divisor.
	aluPkg::operand_t rawQuotient;
	aluPkg::operand_t rawRemainder;

	// ------------------------------------------------------------
	// Zero-divisor detect
	// ------------------------------------------------------------

	assign divideByZero = (divisor == '0);

	// ------------------------------------------------------------
	// Division
	// ------------------------------------------------------------

	assign rawQuotient = dividend / divisor;
	assign rawRemainder = dividend % divisor;

	// Zero out both results on a zero divisor.
	assign quotient = divideByZero ? '0 : rawQuotient;
	assign remainder = divideByZero ? '0 : rawRemainder;

endmodule

`default_nettype wire

// ==== logic/resultSelect.sv ====
// Opcode decoder and result selector with the output register.
// Decodes op one-hot, picks the matching arithmetic result with an AND-OR mux,
// gates the error flags by opcode class and registers result and error.

`timescale 1ns/1ps
`default_nettype none

module resultSelect (
	input wire logic clk,
	input wire logic rstN,
	input wire aluPkg::aluOp_e op,
	input wire aluPkg::arithResults_t arith,
	output aluPkg::result_t result,
	output aluPkg::aluError_t error
);

	// One line per opcode value.
	logic [aluPkg::opCount-1:0] select;
	// Result candidate per opcode value, unused codes stay zero.
	aluPkg::result_t [aluPkg::opCount-1:0] channels;
	// Sum with the overflow bit placed at bit 16.
	aluPkg::result_t addSubWord;
	aluPkg::result_t muxOut;
	aluPkg::aluError_t errorNext;
	logic isAddSub;
	logic isDivide;

	// ------------------------------------------------------------
	// Decoder
	// ------------------------------------------------------------

	always_comb
	begin
		select = '0;
		select[op] = 1'b1;
	end

	// ------------------------------------------------------------
	// Channels and AND-OR mux
	// ------------------------------------------------------------

	// Upper bits zero-extend.
	assign addSubWord = aluPkg::result_t'({arith.addOverflow, arith.sum});

	always_comb
	begin
		channels = '0;
		channels[aluPkg::opMul] = arith.product;
		channels[aluPkg::opDiv] = aluPkg::result_t'(arith.quotient);
		channels[aluPkg::opMod] = aluPkg::result_t'(arith.remainder);
		channels[aluPkg::opAdd] = addSubWord;
		channels[aluPkg::opSub] = addSubWord;
	end

	always_comb
	begin
		muxOut = '0;
		for (int i = 0; i < aluPkg::opCount; i++)
		begin
			muxOut = muxOut | (channels[i] & {aluPkg::resultWidth{select[i]}});
		end
	end

	// ------------------------------------------------------------
	// Error gating
	// ------------------------------------------------------------

	assign isAddSub = select[aluPkg::opAdd] | select[aluPkg::opSub];
	assign isDivide = select[aluPkg::opDiv] | select[aluPkg::opMod];

	// Each flag only counts for its own opcode class.
	assign errorNext.overflow = isAddSub & arith.addOverflow;
	assign errorNext.divideByZero = isDivide & arith.divideByZero;

	// ------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			result <= '0;
			error <= '0;
		end
		else
		begin
			result <= muxOut;
			error <= errorNext;
		end
	end

	// ------------------------------------------------------------
	// Assertions
	// ------------------------------------------------------------

	// Decoder never selects two channels at once.
	aSelectOneHot : assert property (@(posedge clk) disable iff (!rstN)
		$onehot0(select))
		else $error("resultSelect: more than one channel selected");

	// Registered overflow belongs to an add or subtract one cycle back.
	aOverflowOp : assert property (@(posedge clk) disable iff (!rstN)
		error.overflow |-> ($past(op) inside {aluPkg::opAdd, aluPkg::opSub}))
		else $error("resultSelect: overflow flagged for a non add/sub opcode");

	// Divider must have zeroed its outputs.
	aZeroDivResult : assert property (@(posedge clk) disable iff (!rstN)
		error.divideByZero |-> (result == '0))
		else $error("resultSelect: nonzero result with divide-by-zero");

endmodule

`default_nettype wire

// ==== logic/aluCalc.sv ====
// Top level of the 16-bit arithmetic calculator.
// Three combinational units work on every request in parallel; the selector
// picks one result by opcode and registers it, one cycle of latency.

`timescale 1ns/1ps
`default_nettype none

module aluCalc (
	input wire logic clk,
	input wire logic rstN,
	input wire aluPkg::aluRequest_t request,
	output aluPkg::result_t result,
	output aluPkg::aluError_t error
);

	// All unit outputs, gathered for the selector.
	aluPkg::arithResults_t arith;

	// ------------------------------------------------------------
	// Arithmetic units
	// ------------------------------------------------------------

	// Add or subtract, chosen by the opcode.
	addSubUnit uAddSub (
		.a(request.a),
		.b(request.b),
		.op(request.op),
		.sum(arith.sum),
		.overflow(arith.addOverflow)
	);

	// Full 32-bit unsigned product.
	arrayMultiplier uMultiplier (
		.a(request.a),
		.b(request.b),
		.product(arith.product)
	);

	// Quotient and remainder share one divider.
	divideUnit uDivide (
		.dividend(request.a),
		.divisor(request.b),
		.quotient(arith.quotient),
		.remainder(arith.remainder),
		.divideByZero(arith.divideByZero)
	);

	// ------------------------------------------------------------
	// Selection and output register
	// ------------------------------------------------------------

	resultSelect uSelect (
		.clk(clk),
		.rstN(rstN),
		.op(request.op),
		.arith(arith),
		.result(result),
		.error(error)
	);

endmodule

`default_nettype wire

// ==== sim/aluCalcChecks.svh ====
// Checking helpers for the calculator testbench.
// LFSR random source and compare tasks for inclusion in the testbench module.

`ifndef ALU_CALC_CHECKS_SVH
`define ALU_CALC_CHECKS_SVH

// ------------------------------------------------------------
// Random source
// ------------------------------------------------------------

// Fibonacci LFSR with taps at 32, 22, 2 and 1.
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

// One step per bit taken. New bits enter at the bottom.
task automatic drawBits(input int count, output logic [31:0] value);
	value = '0;
	for (int i = 0; i < count; i++)
	begin
		lfsrState = lfsrStep(lfsrState);
		value = {value[30:0], lfsrState[0]};
	end
endtask

// ------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------

task automatic checkResult(input aluPkg::result_t expected, input aluPkg::result_t actual);
	checkCount++;
	if (actual !== expected)
	begin
		errorCount++;
		$display("error at %0d ns: result expected %h, got %h", $time, expected, actual);
	end
endtask

task automatic checkError(input aluPkg::aluError_t expected, input aluPkg::aluError_t actual);
	checkCount++;
	if (actual !== expected)
	begin
		errorCount++;
		$display("error at %0d ns: error expected %b, got %b", $time, expected, actual);
	end
endtask

`endif

// ==== sim/aluCalcTb.sv ====
// Testbench for the 16-bit arithmetic calculator.
// Drives LFSR requests on the falling edge and checks each answer one cycle later.

`timescale 1ns/1ps
`default_nettype none

module aluCalcTb;

	localparam int clkPeriod = 20;
	localparam int resetCycles = 3;
	localparam int numAddSub = 200;
	localparam int numMul = 150;
	localparam int numDiv = 150;
	localparam int numStream = 300;
	// Every test ends with one flush cycle; 100 cycles of margin.
	localparam int watchdogCycles = resetCycles + numAddSub + numMul + numDiv + numStream + 105;

	logic clk;
	logic rstN;
	aluPkg::aluRequest_t request;
	aluPkg::result_t result;
	aluPkg::aluError_t error;
	logic [31:0] lfsrState;
	int checkCount;
	int errorCount;
	// Expectation for the request now in the output register.
	logic pendingValid;
	aluPkg::result_t pendingResult;
	aluPkg::aluError_t pendingError;

	`include "aluCalcChecks.svh"

	aluCalc u_dut (
		.clk(clk),
		.rstN(rstN),
		.request(request),
		.result(result),
		.error(error)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------

	task automatic modelRequest(input aluPkg::aluRequest_t req,
		output aluPkg::result_t expResult, output aluPkg::aluError_t expError);
		logic [16:0] wide;
		logic [15:0] low;
		expResult = '0;
		expError = '0;
		case (req.op)
			aluPkg::opAdd:
			begin
				wide = {1'b0, req.a} + {1'b0, req.b};
				expError.overflow = wide[16];
				expResult = {15'd0, wide};
			end
			aluPkg::opSub:
			begin
				wide = {1'b0, req.a} + {1'b0, ~req.b} + 17'd1;
				// Bit 15 of the low sum is the carry into the top bit.
				low = {1'b0, req.a[14:0]} + {1'b0, ~req.b[14:0]} + 16'd1;
				expError.overflow = low[15] ^ wide[16];
				expResult = {15'd0, expError.overflow, wide[15:0]};
			end
			aluPkg::opMul:
				expResult = aluPkg::result_t'(req.a) * aluPkg::result_t'(req.b);
			aluPkg::opDiv, aluPkg::opMod:
			begin
				if (req.b == '0)
					expError.divideByZero = 1'b1;
				else if (req.op == aluPkg::opDiv)
					expResult = aluPkg::result_t'(req.a / req.b);
				else
					expResult = aluPkg::result_t'(req.a % req.b);
			end
			default:
				expResult = '0;
		endcase
	endtask

	// ------------------------------------------------------------
	// Drive and check
	// ------------------------------------------------------------

	// Checks the request in flight against its expectation.
	task automatic flushRequest();
		@(negedge clk);
		if (pendingValid)
		begin
			checkResult(pendingResult, result);
			checkError(pendingError, error);
		end
		pendingValid = 1'b0;
	endtask

	// Next request goes out on the same falling edge.
	task automatic applyRequest(input aluPkg::aluRequest_t req);
		flushRequest();
		request = req;
		modelRequest(req, pendingResult, pendingError);
		pendingValid = 1'b1;
	endtask

	task automatic drawOperands(inout aluPkg::aluRequest_t req);
		logic [31:0] bits;
		drawBits(16, bits);
		req.a = bits[15:0];
		drawBits(16, bits);
		req.b = bits[15:0];
	endtask

	task automatic reportTest(input string name, input int startChecks, input int startErrors);
		$display("%s: %0d checks, %0d errors", name, checkCount - startChecks,
			errorCount - startErrors);
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------

	initial
	begin
		logic [31:0] bits;
		aluPkg::aluRequest_t req;
		int startChecks;
		int startErrors;
		clk = 1'b0;
		rstN = 1'b0;
		lfsrState = 32'hfc36;
		checkCount = 0;
		errorCount = 0;
		pendingValid = 1'b0;
		// Held through reset, so it must not show until reset is released.
		request = '{a: 16'd1, b: 16'd1, op: aluPkg::opAdd};
		req = request;

		startChecks = checkCount;
		startErrors = errorCount;
		repeat (resetCycles)
		begin
			@(negedge clk);
			checkResult('0, result);
			checkError('0, error);
		end
		rstN = 1'b1;
		#1;
		checkResult('0, result);
		checkError('0, error);
		modelRequest(request, pendingResult, pendingError);
		pendingValid = 1'b1;
		flushRequest();
		reportTest("reset", startChecks, startErrors);

		startChecks = checkCount;
		startErrors = errorCount;
		for (int i = 0; i < numAddSub; i++)
		begin
			drawBits(1, bits);
			req.op = bits[0] ? aluPkg::opSub : aluPkg::opAdd;
			drawOperands(req);
			drawBits(2, bits);
			// Pull some pairs to the signed and unsigned limits.
			if (bits[1:0] == 2'd0)
			begin
				req.a = 16'h7fff - req.a[2:0];
				req.b = 16'h7fff - req.b[2:0];
			end
			else if (bits[1:0] == 2'd1)
			begin
				req.a = 16'hffff - req.a[2:0];
				req.b = 16'hffff - req.b[2:0];
			end
			else if (bits[1:0] == 2'd2)
			begin
				req.a = 16'h7fff - req.a[2:0];
				req.b = 16'hffff - req.b[2:0];
			end
			applyRequest(req);
		end
		flushRequest();
		reportTest("add and subtract", startChecks, startErrors);

		startChecks = checkCount;
		startErrors = errorCount;
		req.op = aluPkg::opMul;
		for (int i = 0; i < numMul; i++)
		begin
			drawOperands(req);
			drawBits(3, bits);
			case (bits[2:0])
				3'd0: req.a = '0;
				3'd1: req.b = 16'd1;
				3'd2: req = '{a: 16'hffff, b: 16'hffff, op: aluPkg::opMul};
				3'd3: req.b = '0;
				default: ;
			endcase
			applyRequest(req);
		end
		flushRequest();
		reportTest("multiply", startChecks, startErrors);

		startChecks = checkCount;
		startErrors = errorCount;
		for (int i = 0; i < numDiv; i++)
		begin
			drawBits(1, bits);
			req.op = bits[0] ? aluPkg::opMod : aluPkg::opDiv;
			drawOperands(req);
			drawBits(2, bits);
			if (bits[1:0] == 2'd0)
				req.b = '0;
			applyRequest(req);
		end
		flushRequest();
		reportTest("divide and modulo", startChecks, startErrors);

		startChecks = checkCount;
		startErrors = errorCount;
		for (int i = 0; i < numStream; i++)
		begin
			drawBits(4, bits);
			req.op = aluPkg::aluOp_e'(bits[3:0]);
			drawOperands(req);
			applyRequest(req);
		end
		flushRequest();
		reportTest("opcode stream", startChecks, startErrors);

		$display("Summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Watchdog sized from the test lengths.
	initial
	begin
		#(watchdogCycles * clkPeriod);
		$display("Run timed out after %0d cycles without finishing", watchdogCycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== aluCalc.f ====
+incdir+sim
logic/aluPkg.sv
logic/addSubUnit.sv
logic/multiplierRow.sv
logic/arrayMultiplier.sv
logic/divideUnit.sv
logic/resultSelect.sv
logic/aluCalc.sv
sim/aluCalcTb.sv
